// File: Makefile
# Verilator build and run of the audio/video test source testbench

VERILATOR ?= verilator
TOP       := tb_av_core
FILELIST  := project.f
OBJ_DIR   := obj_dir
VFLAGS    := --binary --timing --assert --timescale 1ns/100ps --top-module $(TOP)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

// File: bench/av_core_props.sv
////////////////////////////////////////////////////////////
// assertions bound to av_core_top
// sync pulse widths, dac timing and output state in reset
////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module av_core_props (
    input logic          audgen_mclk,
    input logic          reset_n,
    input av_pkg::rgb_t  video_rgb,
    input logic          video_de,
    input logic          video_vs,
    input logic          video_hs,
    input logic          audio_sclk,
    input logic          audio_lrck,
    input logic          audio_dac
);

    // set once reset has been seen at a rising edge
    logic reset_held_q = 1'b0;

    always @(posedge audgen_mclk) begin
        reset_held_q <= !reset_n;
    end

    // syncs are single clock strobes
    vs_single: assert property (@(posedge audgen_mclk) disable iff (!reset_n)
        video_vs |=> !video_vs)
        else $error("video_vs high on two clocks in a row");

    hs_single: assert property (@(posedge audgen_mclk) disable iff (!reset_n)
        video_hs |=> !video_hs)
        else $error("video_hs high on two clocks in a row");

    // data bit moves only as the bit clock falls
    dac_on_fall: assert property (@(posedge audgen_mclk) disable iff (!reset_n)
        (audio_dac != $past(audio_dac)) |-> $fell(audio_sclk))
        else $error("audio_dac changed away from a falling audio_sclk");

    // everything low while reset is held
    reset_quiet: assert property (@(posedge audgen_mclk)
        (!reset_n && reset_held_q) |-> (!video_vs && !video_hs && !video_de &&
            (video_rgb == '0) && !audio_sclk && !audio_lrck && !audio_dac))
        else $error("an output is high during reset");

endmodule

// File: bench/av_trace.txt
// first line: video frames to observe, number of sample pairs
// then one line per audio frame: left sample, right sample (hex)
0002 0009
8001 7ffe
a5a5 5a5a
0000 ffff
ffff 0000
1234 edcb
c3d2 0f1e
7fff 8000
0001 fffe
9bdf 2468

// File: bench/tb_av_core.sv
////////////////////////////////////////////////////////////
// testbench for av_core_top, run from the project root
// samples and video frame count come from bench/av_trace.txt
// video is measured on falling clock edges, audio decoded on sclk
////////////////////////////////////////////////////////////

`timescale 1ns/100ps

`include "av_cfg.svh"

module tb_av_core;

    import av_pkg::*;

    localparam int CLK_PERIOD_NS = 100;
    localparam int FRAME_CLKS    = `AV_H_TOTAL * `AV_V_TOTAL;
    localparam int TRACE_WORDS   = 258;
    localparam int MAX_PAIRS     = (TRACE_WORDS - 2) / 2;

    // grey in the window, same level on r, g and b
    localparam rgb_t FILL_RGB = '{
        red:   8'(`AV_FILL_LEVEL),
        green: 8'(`AV_FILL_LEVEL),
        blue:  8'(`AV_FILL_LEVEL)
    };

    logic        audgen_mclk;
    logic        reset_n;
    sample_t     audio_left;
    sample_t     audio_right;
    rgb_t        video_rgb;
    logic        video_de;
    logic        video_vs;
    logic        video_hs;
    logic        audio_sclk;
    logic        audio_lrck;
    logic        audio_dac;

    // word 0 frames, word 1 pair count, then left/right pairs
    logic [15:0] trace_mem [0:TRACE_WORDS-1];
    int          video_frames;
    int          pair_count;
    int          audio_frames_checked;
    logic        trace_ready;
    int          seed;

    tb_clock_gen #(.PERIOD_NS(CLK_PERIOD_NS)) u_clock (
        .audgen_mclk (audgen_mclk),
        .reset_n     (reset_n)
    );

    av_core_top uut (
        .audgen_mclk (audgen_mclk),
        .reset_n     (reset_n),
        .audio_left  (audio_left),
        .audio_right (audio_right),
        .video_rgb   (video_rgb),
        .video_de    (video_de),
        .video_vs    (video_vs),
        .video_hs    (video_hs),
        .audio_sclk  (audio_sclk),
        .audio_lrck  (audio_lrck),
        .audio_dac   (audio_dac)
    );

    bind av_core_top av_core_props u_props (
        .audgen_mclk (audgen_mclk),
        .reset_n     (reset_n),
        .video_rgb   (video_rgb),
        .video_de    (video_de),
        .video_vs    (video_vs),
        .video_hs    (video_hs),
        .audio_sclk  (audio_sclk),
        .audio_lrck  (audio_lrck),
        .audio_dac   (audio_dac)
    );

    ////////////////////////////////////////////////////////////
    // compare tasks

    task automatic abort_run();
        $display("TEST FAIL");
        $fatal(1, "run stopped at %0t ns", $time);
    endtask

    task automatic check_sample(input string what, input sample_t got, input sample_t exp);
        if (got !== exp) begin
            $display("MISMATCH at %0t ns: %s = %h, expected %h", $time, what, got, exp);
            abort_run();
        end
    endtask

    task automatic check_rgb(input string what, input rgb_t got, input rgb_t exp);
        if (got !== exp) begin
            $display("MISMATCH at %0t ns: %s = %h, expected %h", $time, what, got, exp);
            abort_run();
        end
    endtask

    task automatic check_count(input string what, input int got, input int exp);
        if (got != exp) begin
            $display("MISMATCH at %0t ns: %s = %0d, expected %0d", $time, what, got, exp);
            abort_run();
        end
    endtask

    task automatic check_bit(input string what, input logic got, input logic exp);
        if (got !== exp) begin
            $display("MISMATCH at %0t ns: %s = %b, expected %b", $time, what, got, exp);
            abort_run();
        end
    endtask

    ////////////////////////////////////////////////////////////
    // reset and stimulus

    task automatic check_outputs_low();
        check_bit("video_vs", video_vs, 1'b0);
        check_bit("video_hs", video_hs, 1'b0);
        check_bit("video_de", video_de, 1'b0);
        check_rgb("video_rgb", video_rgb, '0);
        check_bit("audio_sclk", audio_sclk, 1'b0);
        check_bit("audio_lrck", audio_lrck, 1'b0);
        check_bit("audio_dac", audio_dac, 1'b0);
    endtask

    task automatic check_reset_state();
        // first rising edge applies the reset
        @(posedge audgen_mclk);
        @(negedge audgen_mclk);
        check_outputs_low();
        // just after release, before the next rising edge
        @(posedge reset_n);
        #(CLK_PERIOD_NS / 10);
        check_outputs_low();
    endtask

    // next pair lands while the right slot runs
    task automatic drive_samples();
        int idx;
        idx = 0;
        forever begin
            @(posedge audio_lrck);
            @(negedge audgen_mclk);
            audio_left  = trace_mem[2 + 2 * idx];
            audio_right = trace_mem[3 + 2 * idx];
            idx = (idx + 1) % pair_count;
        end
    endtask

    ////////////////////////////////////////////////////////////
    // audio monitors

    task automatic check_audio_clocks();
        int   clk_cnt;
        int   last_rise;
        int   rises;
        logic have_rise;
        logic have_edge;
        logic prev_sclk;
        logic prev_lrck;
        clk_cnt   = 0;
        last_rise = 0;
        rises     = 0;
        have_rise = 1'b0;
        have_edge = 1'b0;
        prev_sclk = audio_sclk;
        prev_lrck = audio_lrck;
        forever begin
            @(negedge audgen_mclk);
            clk_cnt++;
            if (audio_sclk && !prev_sclk) begin
                if (have_rise) begin
                    check_count("audio_sclk period", clk_cnt - last_rise, `AV_SCLK_DIV);
                end
                have_rise = 1'b1;
                last_rise = clk_cnt;
                rises++;
            end
            // word clock toggles once per slot
            if (audio_lrck != prev_lrck) begin
                if (have_edge) begin
                    check_count("audio_sclk periods per lrck phase", rises, `AV_SLOT_BITS);
                end
                have_edge = 1'b1;
                rises     = 0;
            end
            prev_sclk = audio_sclk;
            prev_lrck = audio_lrck;
        end
    endtask

    task automatic decode_audio();
        logic [`AV_SLOT_BITS-1:0] slot_word;
        int                       nbits;
        int                       frame_idx;
        int                       pair_idx;
        logic                     slot_ch;
        sample_t                  exp;
        slot_word = '0;
        nbits     = 0;
        frame_idx = 0;
        slot_ch   = audio_lrck;
        forever begin
            @(posedge audio_sclk);
            if (audio_lrck !== slot_ch) begin
                check_count("audio bits per slot", nbits, `AV_SLOT_BITS);
                // frame 0 carries a pair taken before the first drive
                if (frame_idx > 0) begin
                    pair_idx = (frame_idx - 1) % pair_count;
                    exp = trace_mem[2 + 2 * pair_idx + int'(slot_ch)];
                    check_sample(slot_ch ? "audio_dac right sample" : "audio_dac left sample",
                                 slot_word[`AV_SLOT_BITS-1 -: `AV_SAMPLE_BITS], exp);
                    check_sample("audio_dac zero fill",
                                 slot_word[`AV_SLOT_BITS-`AV_SAMPLE_BITS-1:0], '0);
                    if (slot_ch) begin
                        audio_frames_checked++;
                    end
                end
                // right slot closes the frame
                if (slot_ch) begin
                    frame_idx++;
                end
                nbits   = 0;
                slot_ch = audio_lrck;
            end
            slot_word = {slot_word[`AV_SLOT_BITS-2:0], audio_dac};
            nbits++;
        end
    endtask

    ////////////////////////////////////////////////////////////
    // video measurement

    task automatic measure_video(input int frames);
        int   cyc;
        int   vs_seen;
        int   last_vs;
        int   last_hs;
        int   de_run;
        int   de_lines;
        logic have_hs;
        logic want_first_hs;
        logic prev_de;
        cyc           = 0;
        vs_seen       = 0;
        last_vs       = 0;
        last_hs       = 0;
        de_run        = 0;
        de_lines      = 0;
        have_hs       = 1'b0;
        want_first_hs = 1'b0;
        prev_de       = 1'b0;
        // one extra vsync closes the last frame
        while (vs_seen <= frames) begin
            @(negedge audgen_mclk);
            cyc++;
            if (video_de) begin
                check_rgb("video_rgb", video_rgb, FILL_RGB);
                de_run++;
            end else begin
                check_rgb("video_rgb", video_rgb, '0);
                if (prev_de) begin
                    check_count("video_de run length", de_run, `AV_H_ACTIVE);
                    de_lines++;
                    de_run = 0;
                end
            end
            if (video_hs) begin
                if (have_hs) begin
                    check_count("video_hs period", cyc - last_hs, `AV_H_TOTAL);
                end
                if (want_first_hs) begin
                    check_count("video_vs to video_hs", cyc - last_vs, `AV_HS_OFFSET);
                    want_first_hs = 1'b0;
                end
                have_hs = 1'b1;
                last_hs = cyc;
            end
            if (video_vs) begin
                if (vs_seen > 0) begin
                    check_count("video_vs period", cyc - last_vs, FRAME_CLKS);
                    check_count("video_de lines per frame", de_lines, `AV_V_ACTIVE);
                end
                vs_seen++;
                last_vs       = cyc;
                de_lines      = 0;
                want_first_hs = 1'b1;
            end
            prev_de = video_de;
        end
    endtask

    ////////////////////////////////////////////////////////////
    // run control

    initial begin : main
        seed                 = 10;
        trace_ready          = 1'b0;
        audio_frames_checked = 0;
        // junk before the first drive, never reaches a checked slot
        audio_left  = sample_t'($random(seed));
        audio_right = sample_t'($random(seed));
        $readmemh("bench/av_trace.txt", trace_mem);
        video_frames = int'(trace_mem[0]);
        pair_count   = int'(trace_mem[1]);
        if (video_frames < 1 || pair_count < 1 || pair_count > MAX_PAIRS) begin
            $display("trace header is not usable: %0d frames, %0d sample pairs",
                     video_frames, pair_count);
            abort_run();
        end
        trace_ready = 1'b1;
        check_reset_state();
        fork
            drive_samples();
            decode_audio();
            check_audio_clocks();
        join_none
        measure_video(video_frames);
        if (audio_frames_checked >= 2 * pair_count) begin
            $display("TEST PASS");
            $finish;
        end else begin
            $display("only %0d audio frames were decoded and checked", audio_frames_checked);
            abort_run();
        end
    end

    // requested frames plus one frame of margin
    initial begin : watchdog
        longint limit_ns;
        wait (trace_ready === 1'b1);
        limit_ns = longint'(video_frames + 1) * FRAME_CLKS * CLK_PERIOD_NS;
        #(limit_ns);
        $display("watchdog expired after %0d ns before %0d video frames were measured",
                 limit_ns, video_frames);
        abort_run();
    end

endmodule

// File: bench/tb_clock_gen.sv
////////////////////////////////////////////////////////////
// testbench clock and reset source
// audgen_mclk free running, reset_n released on a falling edge
////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module tb_clock_gen #(
    parameter int PERIOD_NS    = 100,
    parameter int RESET_CYCLES = 3
) (
    output logic audgen_mclk,
    output logic reset_n
);

    // 50 ns high, 50 ns low
    initial begin
        audgen_mclk = 1'b0;
        forever begin
            #(PERIOD_NS / 2) audgen_mclk = ~audgen_mclk;
        end
    end

    // reset held across the first rising edges
    initial begin
        reset_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge audgen_mclk);
        @(negedge audgen_mclk);
        reset_n = 1'b1;
    end

endmodule

// File: hdl/av_core_top.sv
////////////////////////////////////////////////////////////
// top level of the audio/video test source
// one clock domain: pixel clock and audio master clock
// are both audgen_mclk
////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module av_core_top (
    input  logic              audgen_mclk,
    input  logic              reset_n,

    // sample pair, taken at the start of each left slot
    input  av_pkg::sample_t   audio_left,
    input  av_pkg::sample_t   audio_right,

    // video to the scaler
    output av_pkg::rgb_t      video_rgb,
    output logic              video_de,
    output logic              video_vs,
    output logic              video_hs,

    // serial audio
    output logic              audio_sclk,
    output logic              audio_lrck,
    output logic              audio_dac
);

    import av_pkg::*;

    // raster position from the sequencer
    coord_t h_count;
    coord_t v_count;

    // audio pacing strobes
    logic   bit_strobe;
    logic   slot_start;

    ////////////////////////////////////////////////////////////
    // timing source

    av_sequencer u_sequencer (
        .audgen_mclk (audgen_mclk),
        .reset_n     (reset_n),
        .h_count     (h_count),
        .v_count     (v_count),
        .sclk        (audio_sclk),
        .lrck        (audio_lrck),
        .bit_strobe  (bit_strobe),
        .slot_start  (slot_start)
    );

    ////////////////////////////////////////////////////////////
    // video and audio datapaths

    video_out u_video_out (
        .audgen_mclk (audgen_mclk),
        .reset_n     (reset_n),
        .h_count     (h_count),
        .v_count     (v_count),
        .video_rgb   (video_rgb),
        .video_de    (video_de),
        .video_vs    (video_vs),
        .video_hs    (video_hs)
    );

    i2s_serializer u_serializer (
        .audgen_mclk (audgen_mclk),
        .reset_n     (reset_n),
        .audio_left  (audio_left),
        .audio_right (audio_right),
        .lrck        (audio_lrck),
        .bit_strobe  (bit_strobe),
        .slot_start  (slot_start),
        .audio_dac   (audio_dac)
    );

endmodule

// File: hdl/av_pkg.sv
////////////////////////////////////////////////////////////
// shared types for the audio/video test source
// import with av_pkg::* inside a module body
////////////////////////////////////////////////////////////

`include "av_cfg.svh"

package av_pkg;

    // raster counter value, wide enough for 512 lines
    typedef logic [9:0] coord_t;

    // pixel, red in the top byte
    typedef struct packed {
        logic [7:0] red;
        logic [7:0] green;
        logic [7:0] blue;
    } rgb_t;

    // audio sample, sent msb first
    typedef logic [`AV_SAMPLE_BITS-1:0] sample_t;

    // bit position inside one channel slot
    typedef logic [$clog2(`AV_SLOT_BITS)-1:0] slot_bit_t;

endpackage

// File: hdl/av_sequencer.sv
////////////////////////////////////////////////////////////
// raster counters, bit clock divider and slot bit counter
// the strobes pace video_out and the serialiser
////////////////////////////////////////////////////////////

`timescale 1ns/100ps

`include "av_cfg.svh"

module av_sequencer (
    input  logic            audgen_mclk,
    input  logic            reset_n,

    // raster position
    output av_pkg::coord_t  h_count,
    output av_pkg::coord_t  v_count,

    // audio clocks and strobes
    output logic            sclk,
    output logic            lrck,
    output logic            bit_strobe,
    output logic            slot_start
);

    import av_pkg::*;

    // divider width, 2 bits for a divide by 4
    localparam int DIV_W = $clog2(`AV_SCLK_DIV);

    localparam logic [DIV_W-1:0] DIV_LAST = DIV_W'(`AV_SCLK_DIV - 1);
    localparam slot_bit_t        SLOT_LAST = slot_bit_t'(`AV_SLOT_BITS - 1);
    localparam coord_t           H_LAST = coord_t'(`AV_H_TOTAL - 1);
    localparam coord_t           V_LAST = coord_t'(`AV_V_TOTAL - 1);

    logic [DIV_W-1:0] div_cnt;
    slot_bit_t        slot_cnt;
    logic             lrck_q;
    logic             h_wrap;
    logic             v_wrap;

    ////////////////////////////////////////////////////////////
    // raster counters

    // end of line and end of frame
    assign h_wrap = (h_count == H_LAST);
    assign v_wrap = (v_count == V_LAST);

    // h advances every clock, v on each line wrap
    always_ff @(posedge audgen_mclk or negedge reset_n) begin
        if (!reset_n) begin
            h_count <= '0;
            v_count <= '0;
        end else begin
            if (h_wrap) begin
                h_count <= '0;
                if (v_wrap) begin
                    v_count <= '0;
                end else begin
                    v_count <= v_count + 1'b1;
                end
            end else begin
                h_count <= h_count + 1'b1;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // bit clock

    // free running divider
    always_ff @(posedge audgen_mclk or negedge reset_n) begin
        if (!reset_n) begin
            div_cnt <= '0;
        end else begin
            div_cnt <= div_cnt + 1'b1;
        end
    end

    // sclk is the divider msb, high for the second half
    assign sclk = div_cnt[DIV_W-1];

    // last divider value, sclk falls on the next edge
    assign bit_strobe = (div_cnt == DIV_LAST);

    ////////////////////////////////////////////////////////////
    // slot framing

    // end of the 32 bit slot, same clock as the strobe
    assign slot_start = bit_strobe && (slot_cnt == SLOT_LAST);

    always_ff @(posedge audgen_mclk or negedge reset_n) begin
        if (!reset_n) begin
            slot_cnt <= '0;
            lrck_q   <= 1'b0;
        end else begin
            if (bit_strobe) begin
                // wraps from 31 to 0 by width
                slot_cnt <= slot_cnt + 1'b1;
            end
            if (slot_start) begin
                // low selects left
                lrck_q <= ~lrck_q;
            end
        end
    end

    assign lrck = lrck_q;

endmodule

// File: hdl/i2s_serializer.sv
////////////////////////////////////////////////////////////
// left-justified serial audio out with 16 bits msb first
// then zero fill to the end of each 32 bit slot
////////////////////////////////////////////////////////////

`timescale 1ns/100ps

`include "av_cfg.svh"

module i2s_serializer (
    input  logic             audgen_mclk,
    input  logic             reset_n,
    input  av_pkg::sample_t  audio_left,
    input  av_pkg::sample_t  audio_right,
    input  logic             lrck,
    input  logic             bit_strobe,
    input  logic             slot_start,
    output logic             audio_dac
);

    import av_pkg::*;

    // bits still to send after the msb
    localparam slot_bit_t FIRST_LEFT = slot_bit_t'(`AV_SAMPLE_BITS - 1);

    sample_t   right_q;
    sample_t   shift_q;
    sample_t   next_sample;
    slot_bit_t bits_left;
    logic      left_begins;

    ////////////////////////////////////////////////////////////
    // channel select

    // lrck still high here and drops on this edge
    assign left_begins = slot_start && lrck;
    assign next_sample = lrck ? audio_left : right_q;

    // right sample held for the following slot
    // silence in the first right slot after reset
    always_ff @(posedge audgen_mclk or negedge reset_n) begin
        if (!reset_n) begin
            right_q <= '0;
        end else if (left_begins) begin
            right_q <= audio_right;
        end
    end

    ////////////////////////////////////////////////////////////
    // shifter

    // payload shift register
    always_ff @(posedge audgen_mclk) begin
        if (slot_start) begin
            shift_q <= {next_sample[`AV_SAMPLE_BITS-2:0], 1'b0};
        end else if (bit_strobe) begin
            shift_q <= {shift_q[`AV_SAMPLE_BITS-2:0], 1'b0};
        end
    end

    // data bit changes with lrck as sclk falls
    always_ff @(posedge audgen_mclk or negedge reset_n) begin
        if (!reset_n) begin
            bits_left <= '0;
            audio_dac <= 1'b0;
        end else begin
            if (slot_start) begin
                // msb goes out with the word clock change
                audio_dac <= next_sample[`AV_SAMPLE_BITS-1];
                bits_left <= FIRST_LEFT;
            end else if (bit_strobe) begin
                if (bits_left != '0) begin
                    audio_dac <= shift_q[`AV_SAMPLE_BITS-1];
                    bits_left <= bits_left - 1'b1;
                end else begin
                    // zero fill for the rest of the slot
                    audio_dac <= 1'b0;
                end
            end
        end
    end

endmodule

// File: hdl/video_out.sv
////////////////////////////////////////////////////////////
// raster decode to registered sync, enable and colour
// outputs lag the raster position by one clock
////////////////////////////////////////////////////////////

`timescale 1ns/100ps

`include "av_cfg.svh"

module video_out (
    input  logic            audgen_mclk,
    input  logic            reset_n,
    input  av_pkg::coord_t  h_count,
    input  av_pkg::coord_t  v_count,
    output av_pkg::rgb_t    video_rgb,
    output logic            video_de,
    output logic            video_vs,
    output logic            video_hs
);

    import av_pkg::*;

    // visible window bounds
    localparam coord_t H_FIRST = coord_t'(`AV_H_BPORCH);
    localparam coord_t H_END   = coord_t'(`AV_H_BPORCH + `AV_H_ACTIVE);
    localparam coord_t V_FIRST = coord_t'(`AV_V_BPORCH);
    localparam coord_t V_END   = coord_t'(`AV_V_BPORCH + `AV_V_ACTIVE);
    localparam coord_t HS_POS  = coord_t'(`AV_HS_OFFSET);

    // same grey on all three channels
    localparam rgb_t FILL = '{
        red:   8'(`AV_FILL_LEVEL),
        green: 8'(`AV_FILL_LEVEL),
        blue:  8'(`AV_FILL_LEVEL)
    };

    logic in_h;
    logic in_v;
    logic active;

    ////////////////////////////////////////////////////////////
    // window decode

    assign in_h   = (h_count >= H_FIRST) && (h_count < H_END);
    assign in_v   = (v_count >= V_FIRST) && (v_count < V_END);
    assign active = in_h && in_v;

    // vsync at the top left corner, hsync a few clocks later
    always_ff @(posedge audgen_mclk or negedge reset_n) begin
        if (!reset_n) begin
            video_vs  <= 1'b0;
            video_hs  <= 1'b0;
            video_de  <= 1'b0;
            video_rgb <= '0;
        end else begin
            video_vs  <= (h_count == '0) && (v_count == '0);
            video_hs  <= (h_count == HS_POS);
            video_de  <= active;
            // black outside the window
            video_rgb <= active ? FILL : '0;
        end
    end

endmodule

// File: include/av_cfg.svh
////////////////////////////////////////////////////////////
// raster geometry and audio framing constants for the
// 12.288 MHz audio/video test source
// included by the package, the RTL and the testbench
////////////////////////////////////////////////////////////

`ifndef AV_CFG_SVH
`define AV_CFG_SVH

// horizontal timing in master clocks
`define AV_H_TOTAL      400
`define AV_H_ACTIVE     320
`define AV_H_BPORCH     10

// vertical timing in lines
`define AV_V_TOTAL      512
`define AV_V_ACTIVE     240
`define AV_V_BPORCH     10

// hsync fires a few clocks into the line, after vsync
`define AV_HS_OFFSET    3

// master clocks per bit clock period
`define AV_SCLK_DIV     4

// slot framing, active bits sit at the start of the slot
`define AV_SLOT_BITS    32
`define AV_SAMPLE_BITS  16

// grey level on r, g and b inside the visible window
`define AV_FILL_LEVEL   60

`endif

// File: project.f
+incdir+include
hdl/av_pkg.sv
hdl/av_sequencer.sv
hdl/video_out.sv
hdl/i2s_serializer.sv
hdl/av_core_top.sv
bench/tb_clock_gen.sv
bench/av_core_props.sv
bench/tb_av_core.sv
